/* files.f */
src/sys_pkg.sv
src/uart_tx.sv
src/uart_rx.sv
src/cmd_system.sv
src/virtual_uart.sv
src/top_sim.sv
test/tb_top.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
set -e

cd "$(dirname "$0")"

verilator --binary --assert -f files.f --top-module tb_top \
  --Mdir obj_dir -o tb_top_sim

./obj_dir/tb_top_sim > sim.log
cat sim.log

if grep -q "^TESTS PASSED$" sim.log; then
  exit 0
else
  exit 1
fi

/* src/cmd_system.sv */
// ####################
// Serial command interpreter with one GPIO byte in and out
// One command at a time; bytes sent before the answer are lost
// ####################

module cmd_system #(
  parameter int ClockFrequency = 1_000_000,
  parameter int BaudRate       = 100_000
) (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         uart_rx_i,
  output logic                         uart_tx_o,
  input  logic [sys_pkg::GP_WIDTH-1:0] gp_i,
  output logic [sys_pkg::GP_WIDTH-1:0] gp_o
);

  typedef enum logic [1:0] {
    ST_WAIT_OP,
    ST_WAIT_ARG,
    ST_SEND,
    ST_WAIT_DONE
  } cmd_state_e;

  cmd_state_e                   state_q;
  sys_pkg::cmd_op_e             op_q;
  logic [7:0]                   resp_q;
  logic [sys_pkg::GP_WIDTH-1:0] gp_q;

  logic       rx_valid;
  logic [7:0] rx_data;
  logic       tx_valid;
  logic       tx_busy;

  uart_rx #(
    .ClockFrequency(ClockFrequency),
    .BaudRate      (BaudRate)
  ) u_uart_rx (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rx_i   (uart_rx_i),
    .valid_o(rx_valid),
    .data_o (rx_data)
  );

  uart_tx #(
    .ClockFrequency(ClockFrequency),
    .BaudRate      (BaudRate)
  ) u_uart_tx (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(tx_valid),
    .data_i (resp_q),
    .tx_o   (uart_tx_o),
    .busy_o (tx_busy)
  );

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ST_WAIT_OP;
      gp_q    <= '0;
    end else begin
      case (state_q)
        ST_WAIT_OP: begin
          if (rx_valid) begin
            op_q <= sys_pkg::cmd_op_e'(rx_data);
            case (rx_data)
              sys_pkg::CMD_ECHO,
              sys_pkg::CMD_GP_WRITE: state_q <= ST_WAIT_ARG;
              sys_pkg::CMD_GP_READ: begin
                resp_q  <= gp_i;
                state_q <= ST_SEND;
              end
              default: begin
                resp_q  <= sys_pkg::RESP_ERROR;
                state_q <= ST_SEND;
              end
            endcase
          end
        end
        ST_WAIT_ARG: begin
          if (rx_valid) begin
            if (op_q == sys_pkg::CMD_GP_WRITE) begin
              gp_q   <= rx_data;
              // Opcode goes back as the acknowledgement
              resp_q <= sys_pkg::CMD_GP_WRITE;
            end else begin
              resp_q <= rx_data;
            end
            state_q <= ST_SEND;
          end
        end
        ST_SEND: state_q <= ST_WAIT_DONE;
        default: begin
          if (!tx_busy) state_q <= ST_WAIT_OP;
        end
      endcase
    end
  end

  // Transmitter is always idle here since WAIT_DONE precedes any new command
  assign tx_valid = (state_q == ST_SEND);
  assign gp_o     = gp_q;

endmodule

/* src/sys_pkg.sv */
// ####################
// Command opcodes, UART frame states and shared constants
// The clock must be at least 4 times the baud rate
// ####################

package sys_pkg;

  // The command protocol carries exactly one byte of GPIO
  localparam int GP_WIDTH = 8;

  // Command opcodes, the first byte of every command
  typedef enum logic [7:0] {
    CMD_ECHO     = 8'h01,
    CMD_GP_WRITE = 8'h02,
    CMD_GP_READ  = 8'h03
  } cmd_op_e;

  // Position within an 8N1 frame
  typedef enum logic [1:0] {
    UART_IDLE,
    UART_START,
    UART_DATA,
    UART_STOP
  } uart_state_e;

  // Answer to an unknown opcode
  localparam logic [7:0] RESP_ERROR = 8'hEE;

  // Whole clock cycles in one bit period, rounded down
  function automatic int clocks_per_bit(input int clock_frequency,
                                        input int baud_rate);
    return clock_frequency / baud_rate;
  endfunction

endpackage

/* src/top_sim.sv */
// ####################
// Simulation top level, 10 clocks per bit
// Host talks to the system only through the serial lines
// ####################

module top_sim (
  input  logic                         clk_i,
  input  logic                         rst_n_i,
  input  logic                         host_tx_valid_i,
  input  logic [7:0]                   host_tx_data_i,
  output logic                         host_tx_busy_o,
  output logic                         host_rx_valid_o,
  output logic [7:0]                   host_rx_data_o,
  input  logic [sys_pkg::GP_WIDTH-1:0] gp_i,
  output logic [sys_pkg::GP_WIDTH-1:0] gp_o
);

  localparam int ClockFrequency = 1_000_000;
  localparam int BaudRate       = 100_000;

  logic sys_rx;
  logic sys_tx;

  cmd_system #(
    .ClockFrequency(ClockFrequency),
    .BaudRate      (BaudRate)
  ) u_cmd_system (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .uart_rx_i(sys_rx),
    .uart_tx_o(sys_tx),
    .gp_i     (gp_i),
    .gp_o     (gp_o)
  );

  virtual_uart #(
    .ClockFrequency(ClockFrequency),
    .BaudRate      (BaudRate)
  ) u_virtual_uart (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .tx_valid_i(host_tx_valid_i),
    .tx_data_i (host_tx_data_i),
    .tx_busy_o (host_tx_busy_o),
    .tx_o      (sys_rx),
    .rx_i      (sys_tx),
    .rx_valid_o(host_rx_valid_o),
    .rx_data_o (host_rx_data_o)
  );

endmodule

/* src/uart_rx.sv */
// ####################
// 8N1 receiver with a two-stage input synchronizer
// Frames with a low stop bit are dropped without a strobe
// ####################

module uart_rx #(
  parameter int ClockFrequency = 1_000_000,
  parameter int BaudRate       = 100_000
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       rx_i,
  output logic       valid_o,
  output logic [7:0] data_o
);

  localparam int ClksPerBit = sys_pkg::clocks_per_bit(ClockFrequency, BaudRate);
  localparam int CntWidth   = $clog2(ClksPerBit);
  localparam logic [CntWidth-1:0] CntMax  = CntWidth'(ClksPerBit - 1);
  localparam logic [CntWidth-1:0] CntHalf = CntWidth'(ClksPerBit / 2 - 1);

  sys_pkg::uart_state_e state_q;
  logic [CntWidth-1:0]  cnt_q;
  logic [2:0]           bit_q;
  logic [7:0]           shift_q;
  logic                 rx_meta_q;
  logic                 rx_sync_q;
  logic                 rx_last_q;
  logic                 valid_q;
  logic                 bit_end;

  assign bit_end = (cnt_q == CntMax);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      rx_meta_q <= 1'b1;
      rx_sync_q <= 1'b1;
      rx_last_q <= 1'b1;
    end else begin
      rx_meta_q <= rx_i;
      rx_sync_q <= rx_meta_q;
      rx_last_q <= rx_sync_q;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= sys_pkg::UART_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
      valid_q <= 1'b0;
    end else begin
      valid_q <= 1'b0;
      cnt_q   <= bit_end ? '0 : cnt_q + 1'b1;
      case (state_q)
        sys_pkg::UART_IDLE: begin
          cnt_q <= '0;
          if (rx_last_q && !rx_sync_q) state_q <= sys_pkg::UART_START;
        end
        sys_pkg::UART_START: begin
          // Half a bit in, the line must still be low or it was a glitch
          if (cnt_q == CntHalf) begin
            cnt_q   <= '0;
            bit_q   <= '0;
            state_q <= rx_sync_q ? sys_pkg::UART_IDLE : sys_pkg::UART_DATA;
          end
        end
        sys_pkg::UART_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= sys_pkg::UART_STOP;
          end
        end
        default: begin
          if (bit_end) begin
            state_q <= sys_pkg::UART_IDLE;
            valid_q <= rx_sync_q;
          end
        end
      endcase
    end
  end

  // Counter runs from mid-bit, so bit_end lands mid-period
  always_ff @(posedge clk_i) begin
    if (state_q == sys_pkg::UART_DATA && bit_end) begin
      shift_q <= {rx_sync_q, shift_q[7:1]};
    end
  end

  assign valid_o = valid_q;
  assign data_o  = shift_q;

endmodule

/* src/uart_tx.sv */
// ####################
// 8N1 transmitter, LSB first, line idles high
// A strobe while busy is ignored
// ####################

module uart_tx #(
  parameter int ClockFrequency = 1_000_000,
  parameter int BaudRate       = 100_000
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       valid_i,
  input  logic [7:0] data_i,
  output logic       tx_o,
  output logic       busy_o
);

  localparam int ClksPerBit = sys_pkg::clocks_per_bit(ClockFrequency, BaudRate);
  localparam int CntWidth   = $clog2(ClksPerBit);
  localparam logic [CntWidth-1:0] CntMax = CntWidth'(ClksPerBit - 1);

  sys_pkg::uart_state_e state_q;
  logic [CntWidth-1:0]  cnt_q;
  logic [2:0]           bit_q;
  logic [7:0]           shift_q;
  logic                 bit_end;

  assign bit_end = (cnt_q == CntMax);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= sys_pkg::UART_IDLE;
      cnt_q   <= '0;
      bit_q   <= '0;
    end else begin
      cnt_q <= bit_end ? '0 : cnt_q + 1'b1;
      case (state_q)
        sys_pkg::UART_IDLE: begin
          cnt_q <= '0;
          if (valid_i) begin
            state_q <= sys_pkg::UART_START;
          end
        end
        sys_pkg::UART_START: begin
          if (bit_end) begin
            state_q <= sys_pkg::UART_DATA;
            bit_q   <= '0;
          end
        end
        sys_pkg::UART_DATA: begin
          if (bit_end) begin
            bit_q <= bit_q + 1'b1;
            if (bit_q == 3'd7) state_q <= sys_pkg::UART_STOP;
          end
        end
        default: begin
          if (bit_end) state_q <= sys_pkg::UART_IDLE;
        end
      endcase
    end
  end

  // Byte is loaded on acceptance and shifted out LSB first
  always_ff @(posedge clk_i) begin
    if (state_q == sys_pkg::UART_IDLE && valid_i) begin
      shift_q <= data_i;
    end else if (state_q == sys_pkg::UART_DATA && bit_end) begin
      shift_q <= {1'b0, shift_q[7:1]};
    end
  end

  always_comb begin
    case (state_q)
      sys_pkg::UART_START: tx_o = 1'b0;
      sys_pkg::UART_DATA:  tx_o = shift_q[0];
      default:             tx_o = 1'b1;
    endcase
  end

  assign busy_o = (state_q != sys_pkg::UART_IDLE);

endmodule

/* src/virtual_uart.sv */
// ####################
// Host-side serial device built from plain RTL
// Byte strobes only, no FIFO and no back-pressure
// ####################

module virtual_uart #(
  parameter int ClockFrequency = 1_000_000,
  parameter int BaudRate       = 100_000
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  logic       tx_valid_i,
  input  logic [7:0] tx_data_i,
  output logic       tx_busy_o,
  output logic       tx_o,
  input  logic       rx_i,
  output logic       rx_valid_o,
  output logic [7:0] rx_data_o
);

  // Host to system direction
  uart_tx #(
    .ClockFrequency(ClockFrequency),
    .BaudRate      (BaudRate)
  ) u_uart_tx (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .valid_i(tx_valid_i),
    .data_i (tx_data_i),
    .tx_o   (tx_o),
    .busy_o (tx_busy_o)
  );

  // System to host direction
  uart_rx #(
    .ClockFrequency(ClockFrequency),
    .BaudRate      (BaudRate)
  ) u_uart_rx (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .rx_i   (rx_i),
    .valid_o(rx_valid_o),
    .data_o (rx_data_o)
  );

endmodule

/* test/tb_top.sv */
// ####################
// Testbench for top_sim at 10 clocks per bit
// Host waits for each answer before the next command
// ####################

module tb_top;

  localparam int ClksPerBit = 10;

  logic       clk;
  logic       rst_n;
  logic       host_tx_valid;
  logic [7:0] host_tx_data;
  logic       host_tx_busy;
  logic       host_rx_valid;
  logic [7:0] host_rx_data;
  logic [7:0] gp_in;
  logic [7:0] gp_out;

  integer     seed;
  int         check_errors;
  int         tests_run;
  int         tests_failed;
  logic [7:0] gp_model;

  top_sim dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .host_tx_valid_i(host_tx_valid),
    .host_tx_data_i (host_tx_data),
    .host_tx_busy_o (host_tx_busy),
    .host_rx_valid_o(host_rx_valid),
    .host_rx_data_o (host_rx_data),
    .gp_i           (gp_in),
    .gp_o           (gp_out)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [7:0] expected,
                             input logic [7:0] actual);
    assert (actual === expected) else begin
      $display("CHECK FAILED %s expected %h actual %h", name, expected, actual);
      check_errors++;
    end
  endtask

  // Called at a falling edge, returns at a falling edge
  task automatic send_byte(input logic [7:0] value);
    int waited;
    waited = 0;
    while (host_tx_busy && waited < 40 * ClksPerBit) begin
      @(negedge clk);
      waited++;
    end
    if (host_tx_busy) begin
      $display("Host transmitter stayed busy, byte %h was not sent", value);
      check_errors++;
    end else begin
      host_tx_valid = 1'b1;
      host_tx_data  = value;
      @(negedge clk);
      host_tx_valid = 1'b0;
    end
  endtask

  task automatic get_byte(output logic [7:0] value);
    int waited;
    waited = 0;
    value  = 8'hxx;
    while (!host_rx_valid && waited < 40 * ClksPerBit) begin
      @(negedge clk);
      waited++;
    end
    if (host_rx_valid) begin
      value = host_rx_data;
      // Step past the strobe so it is not seen twice
      @(negedge clk);
    end else begin
      $display("No response byte arrived within 40 bit periods");
      check_errors++;
    end
  endtask

  // Expected answer follows the command rules, gp_o is checked after each answer
  task automatic expect_command(input logic [7:0] op, input logic [7:0] arg);
    logic [7:0] expected;
    logic [7:0] resp;
    case (op)
      sys_pkg::CMD_ECHO:     expected = arg;
      sys_pkg::CMD_GP_WRITE: expected = sys_pkg::CMD_GP_WRITE;
      sys_pkg::CMD_GP_READ:  expected = gp_in;
      default:               expected = sys_pkg::RESP_ERROR;
    endcase
    send_byte(op);
    if (op == sys_pkg::CMD_ECHO || op == sys_pkg::CMD_GP_WRITE) begin
      send_byte(arg);
    end
    get_byte(resp);
    check_value("host_rx_data_o", expected, resp);
    if (op == sys_pkg::CMD_GP_WRITE) gp_model = arg;
    check_value("gp_o", gp_model, gp_out);
  endtask

  task automatic finish_test(input string name, input int errors_before);
    tests_run++;
    if (check_errors == errors_before) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: failed", name);
    end
  endtask

  initial begin
    int         errors_before;
    int         kind;
    logic       strobe_seen;
    logic [7:0] arg;
    seed          = 32'hcd45_7ec5;
    rst_n         = 1'b0;
    host_tx_valid = 1'b0;
    host_tx_data  = 8'h00;
    gp_in         = 8'h00;
    check_errors  = 0;
    tests_run     = 0;
    tests_failed  = 0;
    gp_model      = 8'h00;
    repeat (2) @(negedge clk);
    rst_n = 1'b1;

    errors_before = check_errors;
    check_value("host_tx_busy_o", 8'h00, 8'(host_tx_busy));
    check_value("host_rx_valid_o", 8'h00, 8'(host_rx_valid));
    check_value("gp_o", 8'h00, gp_out);
    strobe_seen = 1'b0;
    for (int i = 0; i < 30 * ClksPerBit; i++) begin
      @(negedge clk);
      if (host_rx_valid) strobe_seen = 1'b1;
    end
    check_value("host_rx_valid_o", 8'h00, 8'(strobe_seen));
    finish_test("reset", errors_before);

    errors_before = check_errors;
    expect_command(sys_pkg::CMD_ECHO, 8'hA5);
    expect_command(sys_pkg::CMD_ECHO, 8'h00);
    finish_test("echo", errors_before);

    errors_before = check_errors;
    expect_command(sys_pkg::CMD_GP_WRITE, 8'h3C);
    finish_test("gpio_write", errors_before);

    errors_before = check_errors;
    gp_in = 8'h96;
    expect_command(sys_pkg::CMD_GP_READ, 8'h00);
    finish_test("gpio_read", errors_before);

    errors_before = check_errors;
    expect_command(8'h7F, 8'h00);
    finish_test("unknown_opcode", errors_before);

    errors_before = check_errors;
    for (int n = 0; n < 20; n++) begin
      kind = int'($unsigned($random(seed)) % 3);
      arg  = 8'($random(seed));
      case (kind)
        0: expect_command(sys_pkg::CMD_ECHO, arg);
        1: expect_command(sys_pkg::CMD_GP_WRITE, arg);
        default: begin
          gp_in = arg;
          expect_command(sys_pkg::CMD_GP_READ, 8'h00);
        end
      endcase
    end
    finish_test("random_commands", errors_before);

    $display("tests run %0d, tests failed %0d, checks failed %0d",
             tests_run, tests_failed, check_errors);
    if (check_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule
